// ==== alu8.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module alu8 (
    input  logic [`Z80_DATA_W-1:0] i_x,
    input  logic [`Z80_DATA_W-1:0] i_y,
    input  z80_isa_pkg::alu_op_e   i_func,
    output logic [`Z80_DATA_W-1:0] o_result,
    output logic [`Z80_DATA_W-1:0] o_flags
);

    // One extra bit holds carry out or borrow
    logic [`Z80_DATA_W:0] wide;
    logic                 carry;

    always_comb begin
        wide  = '0;
        carry = 1'b0;
        case (i_func)
            z80_isa_pkg::ALU_ADD: begin
                wide     = {1'b0, i_x} + {1'b0, i_y};
                o_result = wide[`Z80_DATA_W-1:0];
                carry    = wide[`Z80_DATA_W];
            end
            z80_isa_pkg::ALU_SUB: begin
                wide     = {1'b0, i_x} - {1'b0, i_y};
                o_result = wide[`Z80_DATA_W-1:0];
                carry    = wide[`Z80_DATA_W];
            end
            z80_isa_pkg::ALU_AND: o_result = i_x & i_y;
            z80_isa_pkg::ALU_XOR: o_result = i_x ^ i_y;
            z80_isa_pkg::ALU_OR:  o_result = i_x | i_y;
            default:              o_result = i_x;
        endcase
    end

    // Only Z and C are kept, everything else in F is zero
    always_comb begin
        o_flags              = '0;
        o_flags[`Z80_FLAG_Z] = (o_result == '0);
        o_flags[`Z80_FLAG_C] = carry;
    end

endmodule

// ==== cycle_timer.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module cycle_timer (
    input  logic                 clk,
    input  logic                 i_reset,
    input  z80_bus_pkg::mcycle_e i_mcycle,
    output logic                 o_mcycle_done
);

    localparam int LAST_M1  = `Z80_TSTATES_M1 - 1;
    localparam int LAST_MEM = `Z80_TSTATES_MEM - 1;

    logic [`Z80_TSTATE_W-1:0] count_q;

    // Last clock of the cycle depends on its kind
    assign o_mcycle_done = (i_mcycle == z80_bus_pkg::MCYCLE_M1) ?
                           (count_q == LAST_M1) : (count_q == LAST_MEM);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            count_q <= '0;
        end else if (o_mcycle_done) begin
            // Next machine cycle starts over at T1
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

// ==== insn_collector.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module insn_collector (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic [`Z80_DATA_W-1:0] i_bus_rdata,
    input  logic                   i_capture,
    input  logic                   i_clear,
    output logic [`Z80_DATA_W-1:0] o_opcode,
    output logic [`Z80_ADDR_W-1:0] o_operand
);

    // Number of bytes taken for the running instruction
    logic [1:0]             count_q;
    logic [`Z80_DATA_W-1:0] opcode_q;
    logic [`Z80_DATA_W-1:0] lo_q;
    logic [`Z80_DATA_W-1:0] hi_q;

    always_ff @(posedge clk) begin
        if (i_reset || i_clear) begin
            count_q <= '0;
        end else if (i_capture) begin
            count_q <= count_q + 2'd1;
        end
    end

    // Little-endian order, opcode first
    always_ff @(posedge clk) begin
        if (i_reset || i_clear) begin
            // An empty collector reads as NOP
            opcode_q <= z80_isa_pkg::OP_NOP;
            lo_q     <= '0;
            hi_q     <= '0;
        end else if (i_capture) begin
            case (count_q)
                2'd0:    opcode_q <= i_bus_rdata;
                2'd1:    lo_q <= i_bus_rdata;
                default: hi_q <= i_bus_rdata;
            endcase
        end
    end

    // The byte arriving now is already visible to decode
    always_comb begin
        o_opcode  = opcode_q;
        o_operand = {hi_q, lo_q};
        if (i_capture) begin
            case (count_q)
                2'd0:    o_opcode = i_bus_rdata;
                2'd1:    o_operand[`Z80_DATA_W-1:0] = i_bus_rdata;
                default: o_operand[`Z80_ADDR_W-1:`Z80_DATA_W] = i_bus_rdata;
            endcase
        end
    end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module register_file (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_wr,
    input  z80_isa_pkg::reg_sel_e  i_wnum,
    input  logic [`Z80_DATA_W-1:0] i_wdata,
    input  z80_isa_pkg::reg_sel_e  i_rnum,
    output logic [`Z80_DATA_W-1:0] o_rdata,
    output logic [`Z80_DATA_W-1:0] o_reg_a,
    input  logic                   i_f_wr,
    input  logic [`Z80_DATA_W-1:0] i_f_wdata,
    output logic [`Z80_DATA_W-1:0] o_reg_f
);

    // Indexed by register code, slot 6 is never written and reads zero
    logic [`Z80_DATA_W-1:0] regs [8];
    logic [`Z80_DATA_W-1:0] f_q;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr && (i_wnum != 3'd6)) begin
            regs[i_wnum] <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            f_q <= '0;
        end else if (i_f_wr) begin
            f_q <= i_f_wdata;
        end
    end

    assign o_rdata = regs[i_rnum];
    assign o_reg_a = regs[z80_isa_pkg::REG_A];
    assign o_reg_f = f_q;

endmodule

// ==== sequencer_control.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module sequencer_control (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_mcycle_done,
    input  logic [`Z80_DATA_W-1:0] i_bus_rdata,
    input  logic [`Z80_DATA_W-1:0] i_opcode,
    input  logic [`Z80_ADDR_W-1:0] i_operand,
    input  logic [`Z80_DATA_W-1:0] i_reg_rdata,
    input  logic [`Z80_DATA_W-1:0] i_reg_a,
    input  logic [`Z80_DATA_W-1:0] i_reg_f,
    input  logic [`Z80_DATA_W-1:0] i_alu_result,
    input  logic [`Z80_DATA_W-1:0] i_alu_flags,
    output z80_bus_pkg::mcycle_e   o_mcycle,
    output logic                   o_capture,
    output logic                   o_clear,
    output z80_isa_pkg::reg_sel_e  o_reg_rnum,
    output logic                   o_reg_wr,
    output z80_isa_pkg::reg_sel_e  o_reg_wnum,
    output logic [`Z80_DATA_W-1:0] o_reg_wdata,
    output logic                   o_f_wr,
    output logic [`Z80_DATA_W-1:0] o_f_wdata,
    output z80_isa_pkg::alu_op_e   o_alu_func,
    output logic [`Z80_DATA_W-1:0] o_alu_y,
    output logic [`Z80_ADDR_W-1:0] o_addr,
    output logic                   o_mem_rd,
    output logic                   o_mem_wr,
    output logic [`Z80_DATA_W-1:0] o_bus_wdata,
    output logic                   o_done,
    output logic                   o_opcode_fetch,
    output logic                   o_halted
);

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_OPERAND_LO,
        ST_OPERAND_HI,
        ST_DATA,
        ST_HALTED
    } state_e;

    state_e                 state_q;
    state_e                 next_state;
    z80_bus_pkg::mcycle_e   next_mcycle;
    logic [`Z80_ADDR_W-1:0] ip_q;
    logic [`Z80_ADDR_W-1:0] ip_inc;
    logic [`Z80_ADDR_W-1:0] next_ip;
    logic [`Z80_ADDR_W-1:0] next_addr;
    logic                   next_rd;
    logic                   next_wr;
    logic                   insn_end;
    logic                   wr_reg;
    logic                   wr_f;
    logic                   is_ld_r_n;
    logic                   is_alu;
    logic                   alu_known;
    logic                   is_mem_op;
    logic                   is_jump;
    logic                   jump_taken;

    // ALU takes A and the register named by the low opcode field
    assign o_reg_rnum  = z80_isa_pkg::reg_sel_e'(i_opcode[2:0]);
    assign o_alu_func  = z80_isa_pkg::alu_op_e'(i_opcode[5:3]);
    assign o_alu_y     = i_reg_rdata;
    assign o_f_wdata   = i_alu_flags;
    assign o_reg_wdata = (state_q == ST_FETCH) ? i_alu_result : i_bus_rdata;

    always_comb begin
        case (o_alu_func)
            z80_isa_pkg::ALU_ADD, z80_isa_pkg::ALU_SUB, z80_isa_pkg::ALU_AND,
            z80_isa_pkg::ALU_XOR, z80_isa_pkg::ALU_OR: alu_known = 1'b1;
            default: alu_known = 1'b0;
        endcase
    end

    // Code 6 in either field is the (HL) form and runs as NOP
    assign is_ld_r_n = (i_opcode[7:6] == 2'b00) && (i_opcode[2:0] == 3'b110) &&
                       (i_opcode[5:3] != 3'b110);
    assign is_alu    = (i_opcode[7:6] == 2'b10) && (i_opcode[2:0] != 3'b110) && alu_known;
    assign is_mem_op = (i_opcode == z80_isa_pkg::OP_LD_A_IND) ||
                       (i_opcode == z80_isa_pkg::OP_LD_IND_A);
    assign is_jump   = (i_opcode == z80_isa_pkg::OP_JP) ||
                       (i_opcode == z80_isa_pkg::OP_JP_Z) ||
                       (i_opcode == z80_isa_pkg::OP_JP_C);
    assign jump_taken = (i_opcode == z80_isa_pkg::OP_JP) ||
                        ((i_opcode == z80_isa_pkg::OP_JP_Z) && i_reg_f[`Z80_FLAG_Z]) ||
                        ((i_opcode == z80_isa_pkg::OP_JP_C) && i_reg_f[`Z80_FLAG_C]);
    assign ip_inc = ip_q + 1'b1;

    always_comb begin
        next_state  = state_q;
        next_mcycle = z80_bus_pkg::MCYCLE_M1;
        next_addr   = ip_inc;
        next_ip     = ip_inc;
        next_rd     = 1'b1;
        next_wr     = 1'b0;
        insn_end    = 1'b0;
        wr_reg      = 1'b0;
        wr_f        = 1'b0;
        o_reg_wnum  = z80_isa_pkg::REG_A;
        case (state_q)
            ST_FETCH: begin
                if (is_ld_r_n || is_mem_op || is_jump) begin
                    next_state = ST_OPERAND_LO;
                    next_mcycle = z80_bus_pkg::MCYCLE_MEM_RD;
                end else if (i_opcode == z80_isa_pkg::OP_HALT) begin
                    next_state = ST_HALTED;
                    next_rd    = 1'b0;
                    insn_end   = 1'b1;
                end else begin
                    // ALU group or anything run as NOP
                    insn_end = 1'b1;
                    wr_reg   = is_alu;
                    wr_f     = is_alu;
                end
            end
            ST_OPERAND_LO: begin
                if (is_ld_r_n) begin
                    next_state = ST_FETCH;
                    insn_end   = 1'b1;
                    wr_reg     = 1'b1;
                    o_reg_wnum = z80_isa_pkg::reg_sel_e'(i_opcode[5:3]);
                end else begin
                    next_state  = ST_OPERAND_HI;
                    next_mcycle = z80_bus_pkg::MCYCLE_MEM_RD;
                end
            end
            ST_OPERAND_HI: begin
                if (is_mem_op) begin
                    next_state = ST_DATA;
                    next_addr  = i_operand;
                    if (i_opcode == z80_isa_pkg::OP_LD_IND_A) begin
                        next_mcycle = z80_bus_pkg::MCYCLE_MEM_WR;
                        next_rd     = 1'b0;
                        next_wr     = 1'b1;
                    end else begin
                        next_mcycle = z80_bus_pkg::MCYCLE_MEM_RD;
                    end
                end else begin
                    next_state = ST_FETCH;
                    insn_end   = 1'b1;
                    if (jump_taken) begin
                        next_ip   = i_operand;
                        next_addr = i_operand;
                    end
                end
            end
            ST_DATA: begin
                // IP already points past the operand
                next_state = ST_FETCH;
                next_addr  = ip_q;
                next_ip    = ip_q;
                insn_end   = 1'b1;
                wr_reg     = (i_opcode == z80_isa_pkg::OP_LD_A_IND);
            end
            default: begin
                next_addr = o_addr;
                next_ip   = ip_q;
                next_rd   = 1'b0;
            end
        endcase
    end

    assign o_done         = i_mcycle_done && insn_end;
    assign o_opcode_fetch = o_done && (next_state != ST_HALTED);
    assign o_clear        = o_done;
    assign o_capture      = i_mcycle_done && (state_q != ST_DATA) && (state_q != ST_HALTED);
    assign o_reg_wr       = i_mcycle_done && wr_reg;
    assign o_f_wr         = i_mcycle_done && wr_f;

    // Reset parks the machine at T1 of the first M1
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q  <= ST_FETCH;
            o_mcycle <= z80_bus_pkg::MCYCLE_M1;
            o_addr   <= `Z80_RESET_IP;
            ip_q     <= `Z80_RESET_IP;
            o_mem_rd <= 1'b1;
            o_mem_wr <= 1'b0;
            o_halted <= 1'b0;
        end else if (i_mcycle_done) begin
            state_q  <= next_state;
            o_mcycle <= next_mcycle;
            o_addr   <= next_addr;
            ip_q     <= next_ip;
            o_mem_rd <= next_rd;
            o_mem_wr <= next_wr;
            o_halted <= (next_state == ST_HALTED);
        end
    end

    always_ff @(posedge clk) begin
        if (i_mcycle_done && next_wr) begin
            o_bus_wdata <= i_reg_a;
        end
    end

endmodule

// ==== tb_memory.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module tb_memory (
    input  logic                   clk,
    input  logic [`Z80_ADDR_W-1:0] i_addr,
    input  logic                   i_rd,
    input  logic                   i_wr,
    input  logic [`Z80_DATA_W-1:0] i_wdata,
    output logic [`Z80_DATA_W-1:0] o_rdata
);

    // Only the low address byte selects a location
    logic [`Z80_DATA_W-1:0] mem [256];

    // Read data follows the address while the read strobe is high
    assign o_rdata = i_rd ? mem[i_addr[7:0]] : '0;

    // A write repeats on every clock of the cycle with the same data
    always @(posedge clk) begin
        if (i_wr) begin
            mem[i_addr[7:0]] <= i_wdata;
        end
    end

endmodule

// ==== tb_z80_core.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module tb_z80_core;

    localparam int HALT_TIMEOUT = 3000;
    localparam int ROUNDS       = 4;

    logic                   clk = 1'b0;
    logic                   i_reset;
    logic [`Z80_DATA_W-1:0] bus_rdata;
    logic [`Z80_ADDR_W-1:0] o_addr;
    logic                   o_mem_rd;
    logic                   o_mem_wr;
    logic [`Z80_DATA_W-1:0] o_bus_wdata;
    logic                   o_done;
    logic                   o_opcode_fetch;
    logic                   o_halted;

    integer      seed;
    logic [7:0]  pc;
    logic [7:0]  ref_mem [256];
    logic [7:0]  m_reg [8];
    logic        m_z;
    logic        m_c;
    int          exp_len [$];
    logic        exp_fetch [$];
    logic [15:0] exp_wr_addr [$];
    logic [7:0]  exp_wr_data [$];
    string       exp_wr_name [$];
    int          cyc;
    int          last_done;
    int          done_count;
    int          e_len;
    logic        e_fetch;
    logic        wr_prev;
    logic [15:0] cur_wr_addr;
    logic [7:0]  cur_wr_data;
    string       cur_wr_name;

    always #50 clk = ~clk;

    z80_core DUT (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_bus_rdata    (bus_rdata),
        .o_addr         (o_addr),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_bus_wdata    (o_bus_wdata),
        .o_done         (o_done),
        .o_opcode_fetch (o_opcode_fetch),
        .o_halted       (o_halted)
    );

    tb_memory u_mem (
        .clk     (clk),
        .i_addr  (o_addr),
        .i_rd    (o_mem_rd),
        .i_wr    (o_mem_wr),
        .i_wdata (o_bus_wdata),
        .o_rdata (bus_rdata)
    );

    task automatic stop_on_error(input string line);
        $display("TEST FAIL");
        $display("%s", line);
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h",
                                name, expected, actual));
    endtask

    // Odd multiplier keeps every location distinct
    function automatic logic [7:0] fill_byte(input int a);
        fill_byte = a[7:0] * 8'd59 + 8'd17;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        rand_byte = r[7:0];
    endfunction

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    // Any register code except 6
    function automatic logic [2:0] rand_reg();
        int k;
        k = rand_below(7);
        rand_reg = (k == 6) ? 3'd7 : k[2:0];
    endfunction

    function automatic logic [2:0] rand_alu_op();
        case (rand_below(5))
            0:       rand_alu_op = z80_isa_pkg::ALU_ADD;
            1:       rand_alu_op = z80_isa_pkg::ALU_SUB;
            2:       rand_alu_op = z80_isa_pkg::ALU_AND;
            3:       rand_alu_op = z80_isa_pkg::ALU_XOR;
            default: rand_alu_op = z80_isa_pkg::ALU_OR;
        endcase
    endfunction

    task automatic poke(input logic [7:0] a, input logic [7:0] d);
        ref_mem[a] = d;
        u_mem.mem[a] = d;
    endtask

    task automatic put_byte(input logic [7:0] b);
        poke(pc, b);
        pc = pc + 8'd1;
    endtask

    // One M1 plus three clocks for each further memory cycle
    task automatic expect_insn(input int mem_cycles, input logic fetch);
        exp_len.push_back(`Z80_TSTATES_M1 + `Z80_TSTATES_MEM * mem_cycles);
        exp_fetch.push_back(fetch);
    endtask

    task automatic expect_write(input logic [15:0] a, input logic [7:0] d, input string name);
        exp_wr_addr.push_back(a);
        exp_wr_data.push_back(d);
        exp_wr_name.push_back(name);
        ref_mem[a[7:0]] = d;
    endtask

    task automatic gen_ld_r_n(input logic [2:0] r, input logic [7:0] n);
        put_byte({2'b00, r, 3'b110});
        put_byte(n);
        m_reg[r] = n;
        expect_insn(1, 1'b1);
    endtask

    task automatic gen_alu(input logic [2:0] op, input logic [2:0] r);
        int x;
        int y;
        int res;
        put_byte({2'b10, op, r});
        x = m_reg[7];
        y = m_reg[r];
        case (op)
            z80_isa_pkg::ALU_ADD: begin
                res = x + y;
                m_c = (res > 255);
            end
            z80_isa_pkg::ALU_SUB: begin
                res = x - y;
                m_c = (x < y);
            end
            z80_isa_pkg::ALU_AND: begin
                res = x & y;
                m_c = 1'b0;
            end
            z80_isa_pkg::ALU_XOR: begin
                res = x ^ y;
                m_c = 1'b0;
            end
            default: begin
                res = x | y;
                m_c = 1'b0;
            end
        endcase
        m_reg[7] = res[7:0];
        m_z = (res[7:0] == 8'h00);
        expect_insn(0, 1'b1);
    endtask

    task automatic gen_store(input logic [15:0] a, input string name);
        put_byte(z80_isa_pkg::OP_LD_IND_A);
        put_byte(a[7:0]);
        put_byte(a[15:8]);
        expect_insn(3, 1'b1);
        expect_write(a, m_reg[7], name);
    endtask

    task automatic gen_load(input logic [15:0] a);
        put_byte(z80_isa_pkg::OP_LD_A_IND);
        put_byte(a[7:0]);
        put_byte(a[15:8]);
        m_reg[7] = ref_mem[a[7:0]];
        expect_insn(3, 1'b1);
    endtask

    // JP cc,taken then JP join, and only the taken path stores its marker
    task automatic gen_cond_block(input logic [7:0] op, input logic taken,
                                  input logic [7:0] marker, input string name);
        logic [7:0] start;
        start = pc;
        put_byte(op);
        put_byte(start + 8'd6);
        put_byte(8'h00);
        put_byte(z80_isa_pkg::OP_JP);
        put_byte(start + 8'd9);
        put_byte(8'h00);
        put_byte(z80_isa_pkg::OP_LD_IND_A);
        put_byte(marker);
        put_byte(8'h00);
        expect_insn(2, 1'b1);
        if (taken) begin
            expect_insn(3, 1'b1);
            expect_write({8'h00, marker}, m_reg[7], name);
        end else begin
            expect_insn(2, 1'b1);
        end
    endtask

    // The store jumped over here must never reach the bus
    task automatic gen_skip_block();
        logic [7:0] start;
        start = pc;
        put_byte(z80_isa_pkg::OP_JP);
        put_byte(start + 8'd6);
        put_byte(8'h00);
        put_byte(z80_isa_pkg::OP_LD_IND_A);
        put_byte(8'hef);
        put_byte(8'h00);
        expect_insn(2, 1'b1);
    endtask

    // Code below 0xC0, scratch C0-DF, markers E0-EF, preset bytes F0-FF
    task automatic build_program();
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] slot;
        logic [7:0] marker;
        for (int a = 0; a < 256; a++) begin
            poke(a[7:0], fill_byte(a));
        end
        for (int a = 8'hf0; a < 256; a++) begin
            poke(a[7:0], rand_byte());
        end
        for (int i = 0; i < 8; i++) begin
            m_reg[i] = 8'h00;
        end
        m_z    = 1'b0;
        m_c    = 1'b0;
        pc     = 8'h00;
        marker = 8'he0;
        for (int round = 0; round < ROUNDS; round++) begin
            repeat (3) gen_ld_r_n(rand_reg(), rand_byte());
            repeat (3) gen_alu(rand_alu_op(), rand_reg());
            slot = 8'hc0 + (rand_byte() & 8'h1f);
            gen_store({8'h00, slot}, "alu_store");
            slot = 8'hf0 + (rand_byte() & 8'h0f);
            gen_load({8'h00, slot});
            slot = 8'hc0 + (rand_byte() & 8'h1f);
            gen_store({8'h00, slot}, "reload_store");
            // First round forces Z, second forces a borrow
            x = rand_byte();
            y = rand_byte();
            if (round == 0) begin
                y = x;
            end else if (round == 1) begin
                x = x & 8'h7f;
                y = x + 8'h80;
            end
            gen_ld_r_n(z80_isa_pkg::REG_A, x);
            gen_ld_r_n(z80_isa_pkg::REG_B, y);
            gen_alu(z80_isa_pkg::ALU_SUB, z80_isa_pkg::REG_B);
            gen_cond_block(z80_isa_pkg::OP_JP_Z, m_z, marker, "jp_z_marker");
            gen_cond_block(z80_isa_pkg::OP_JP_C, m_c, marker + 8'd1, "jp_c_marker");
            gen_skip_block();
            marker = marker + 8'd2;
        end
        put_byte(z80_isa_pkg::OP_HALT);
        expect_insn(0, 1'b0);
    endtask

    // Outputs are sampled on the falling edge, half a period after they change
    always @(negedge clk) begin
        if (i_reset === 1'b0) begin
            cyc = cyc + 1;
            assert (!$isunknown({o_addr, o_mem_rd, o_mem_wr, o_done, o_opcode_fetch, o_halted}))
                else stop_on_error("A bus or status output of the DUT is unknown after reset");
            if (cyc == 1) begin
                assert (o_mem_rd === 1'b1)
                    else report_mismatch("first_fetch o_mem_rd", 1, o_mem_rd);
                assert (o_addr === `Z80_RESET_IP)
                    else report_mismatch("first_fetch o_addr", `Z80_RESET_IP, o_addr);
                assert ({o_mem_wr, o_done, o_halted} === 3'b000)
                    else report_mismatch("reset_state wr_done_halted", 0,
                                         {o_mem_wr, o_done, o_halted});
            end
            assert (!(o_mem_rd && o_mem_wr))
                else stop_on_error("o_mem_rd and o_mem_wr are high in the same clock");
            assert (!o_opcode_fetch || o_done)
                else stop_on_error("o_opcode_fetch pulsed without o_done");
            assert (!o_halted || exp_len.size() == 0)
                else stop_on_error("o_halted rose before the program reached HALT");
            if (o_mem_wr && !wr_prev) begin
                assert (exp_wr_addr.size() != 0)
                    else stop_on_error("The DUT started a memory write that was not expected");
                cur_wr_addr = exp_wr_addr.pop_front();
                cur_wr_data = exp_wr_data.pop_front();
                cur_wr_name = exp_wr_name.pop_front();
            end
            // Address and data must hold for the whole write cycle
            if (o_mem_wr) begin
                assert (o_addr == cur_wr_addr)
                    else report_mismatch({cur_wr_name, " address"}, cur_wr_addr, o_addr);
                assert (o_bus_wdata == cur_wr_data)
                    else report_mismatch({cur_wr_name, " data"}, cur_wr_data, o_bus_wdata);
            end
            wr_prev = o_mem_wr;
            if (o_done) begin
                assert (exp_len.size() != 0)
                    else stop_on_error("o_done pulsed after the last expected instruction");
                e_len      = exp_len.pop_front();
                e_fetch    = exp_fetch.pop_front();
                done_count = done_count + 1;
                assert (cyc - last_done == e_len)
                    else report_mismatch($sformatf("insn_length #%0d", done_count),
                                         e_len, cyc - last_done);
                assert (o_opcode_fetch == e_fetch)
                    else report_mismatch($sformatf("opcode_fetch #%0d", done_count),
                                         e_fetch, o_opcode_fetch);
                last_done = cyc;
            end
        end
    end

    initial begin
        int waited;
        i_reset    = 1'b1;
        seed       = 32'h31dca4ae;
        cyc        = 0;
        last_done  = 0;
        done_count = 0;
        wr_prev    = 1'b0;
        build_program();
        repeat (8) @(posedge clk);
        i_reset <= 1'b0;

        waited = 0;
        while (o_halted !== 1'b1) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > HALT_TIMEOUT) begin
                stop_on_error("Timed out waiting for o_halted, the core seems to hang");
            end
        end

        // Parked core keeps every strobe low
        repeat (50) begin
            @(negedge clk);
            assert (o_halted === 1'b1)
                else report_mismatch("halt_hold o_halted", 1, o_halted);
            assert (o_mem_rd === 1'b0 && o_mem_wr === 1'b0 && o_done === 1'b0)
                else stop_on_error("A bus strobe or done pulse appeared after HALT");
        end

        if (exp_len.size() == 0 && exp_wr_addr.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            report_mismatch("pending_expectations", 0, exp_len.size() + exp_wr_addr.size());
        end
    end

endmodule

// ==== z80_bus_pkg.sv ====
package z80_bus_pkg;

    // Kind of the machine cycle on the bus
    // M1 is the four clock opcode fetch, the others take three clocks
    typedef enum logic [1:0] {
        MCYCLE_M1     = 2'd0,
        MCYCLE_MEM_RD = 2'd1,
        MCYCLE_MEM_WR = 2'd2
    } mcycle_e;

endpackage

// ==== z80_core.f ====
+incdir+.
z80_isa_pkg.sv
z80_bus_pkg.sv
cycle_timer.sv
insn_collector.sv
register_file.sv
alu8.sv
sequencer_control.sv
z80_core.sv
tb_memory.sv
tb_z80_core.sv

// ==== z80_core.sv ====
`timescale 1ns/1ps
`include "z80_settings.svh"

module z80_core (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic [`Z80_DATA_W-1:0] i_bus_rdata,
    output logic [`Z80_ADDR_W-1:0] o_addr,
    output logic                   o_mem_rd,
    output logic                   o_mem_wr,
    output logic [`Z80_DATA_W-1:0] o_bus_wdata,
    output logic                   o_done,
    output logic                   o_opcode_fetch,
    output logic                   o_halted
);

    z80_bus_pkg::mcycle_e   mcycle;
    logic                   mcycle_done;
    logic                   capture;
    logic                   clear;
    logic [`Z80_DATA_W-1:0] opcode;
    logic [`Z80_ADDR_W-1:0] operand;
    z80_isa_pkg::reg_sel_e  reg_rnum;
    z80_isa_pkg::reg_sel_e  reg_wnum;
    logic                   reg_wr;
    logic [`Z80_DATA_W-1:0] reg_wdata;
    logic [`Z80_DATA_W-1:0] reg_rdata;
    logic [`Z80_DATA_W-1:0] reg_a;
    logic [`Z80_DATA_W-1:0] reg_f;
    logic                   f_wr;
    logic [`Z80_DATA_W-1:0] f_wdata;
    z80_isa_pkg::alu_op_e   alu_func;
    logic [`Z80_DATA_W-1:0] alu_y;
    logic [`Z80_DATA_W-1:0] alu_result;
    logic [`Z80_DATA_W-1:0] alu_flags;

    sequencer_control u_control (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_mcycle_done  (mcycle_done),
        .i_bus_rdata    (i_bus_rdata),
        .i_opcode       (opcode),
        .i_operand      (operand),
        .i_reg_rdata    (reg_rdata),
        .i_reg_a        (reg_a),
        .i_reg_f        (reg_f),
        .i_alu_result   (alu_result),
        .i_alu_flags    (alu_flags),
        .o_mcycle       (mcycle),
        .o_capture      (capture),
        .o_clear        (clear),
        .o_reg_rnum     (reg_rnum),
        .o_reg_wr       (reg_wr),
        .o_reg_wnum     (reg_wnum),
        .o_reg_wdata    (reg_wdata),
        .o_f_wr         (f_wr),
        .o_f_wdata      (f_wdata),
        .o_alu_func     (alu_func),
        .o_alu_y        (alu_y),
        .o_addr         (o_addr),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_bus_wdata    (o_bus_wdata),
        .o_done         (o_done),
        .o_opcode_fetch (o_opcode_fetch),
        .o_halted       (o_halted)
    );

    cycle_timer u_timer (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_mcycle      (mcycle),
        .o_mcycle_done (mcycle_done)
    );

    insn_collector u_collector (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_bus_rdata (i_bus_rdata),
        .i_capture   (capture),
        .i_clear     (clear),
        .o_opcode    (opcode),
        .o_operand   (operand)
    );

    register_file u_regs (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_wr      (reg_wr),
        .i_wnum    (reg_wnum),
        .i_wdata   (reg_wdata),
        .i_rnum    (reg_rnum),
        .o_rdata   (reg_rdata),
        .o_reg_a   (reg_a),
        .i_f_wr    (f_wr),
        .i_f_wdata (f_wdata),
        .o_reg_f   (reg_f)
    );

    // Accumulator is always the first ALU operand
    alu8 u_alu (
        .i_x      (reg_a),
        .i_y      (alu_y),
        .i_func   (alu_func),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

endmodule

// ==== z80_isa_pkg.sv ====
`include "z80_settings.svh"

package z80_isa_pkg;

    // Fixed opcodes with their real Z80 encodings
    // LD r,n and the ALU group are decoded by bit fields instead
    typedef enum logic [`Z80_DATA_W-1:0] {
        OP_NOP      = 8'h00,
        OP_LD_IND_A = 8'h32,
        OP_LD_A_IND = 8'h3a,
        OP_HALT     = 8'h76,
        OP_JP       = 8'hc3,
        OP_JP_Z     = 8'hca,
        OP_JP_C     = 8'hda
    } opcode_e;

    // Operation field of the 10ooorrr group
    // ADC, SBC and CP are outside the subset and run as NOP
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b010,
        ALU_AND = 3'b100,
        ALU_XOR = 3'b101,
        ALU_OR  = 3'b110
    } alu_op_e;

    // Register field of an opcode
    // Code 6 selects (HL) on a real Z80 and means no register here
    typedef enum logic [2:0] {
        REG_B = 3'd0,
        REG_C = 3'd1,
        REG_D = 3'd2,
        REG_E = 3'd3,
        REG_H = 3'd4,
        REG_L = 3'd5,
        REG_A = 3'd7
    } reg_sel_e;

endpackage

// ==== z80_settings.svh ====
`ifndef Z80_SETTINGS_SVH
`define Z80_SETTINGS_SVH

// Bus widths
`define Z80_DATA_W 8
`define Z80_ADDR_W 16

// Clocks per machine cycle and the width of the T-state counter
`define Z80_TSTATES_M1 4
`define Z80_TSTATES_MEM 3
`define Z80_TSTATE_W 3

// Bit positions in F
`define Z80_FLAG_Z 6
`define Z80_FLAG_C 0

// First opcode fetch address
`define Z80_RESET_IP 16'h0000

`endif
